// File: cache/cache_ctrl.sv
module cache_ctrl (
    input  logic                                 i_clock,
    input  logic                                 i_rst_n,

    // processor side
    input  logic                                 i_req,
    input  logic                                 i_wr,
    input  logic [cache_pkg::addr_width-1:0]     i_addr,
    input  logic [cache_pkg::data_width-1:0]     i_wdata,
    output logic                                 o_done,
    output logic                                 o_busy,
    output logic [cache_pkg::data_width-1:0]     o_rdata,

    // backing memory
    mem_port_if.master                           mem,

    // tag store
    output logic [cache_pkg::index_bits-1:0]     o_tag_index,
    output logic                                 o_fill,
    output logic [cache_pkg::tag_bits-1:0]       o_fill_tag,
    output logic                                 o_set_dirty,
    input  logic [cache_pkg::tag_bits-1:0]       i_tag,
    input  logic                                 i_valid,
    input  logic                                 i_dirty,

    // data ram
    output logic [cache_pkg::mem_addr_width-1:0] o_ram_addr,
    output logic                                 o_ram_wr,
    output logic [cache_pkg::data_width-1:0]     o_ram_wdata,
    input  logic [cache_pkg::data_width-1:0]     i_ram_rdata
);

    cache_pkg::ctrl_state_t           state;
    cache_pkg::cache_addr_t           req_addr;
    cache_pkg::cache_addr_t           mem_addr;
    logic                             req_wr;
    logic [cache_pkg::data_width-1:0] req_wdata;
    logic [cache_pkg::offset_bits-1:0] word_cnt;
    logic                             last_word;
    logic                             hit;
    logic                             serve;
    logic                             line_xfer;

    // ####################
    // sequencing
    // ####################

    assign hit       = i_valid && (i_tag == req_addr.fields.tag);
    assign last_word = (word_cnt == cache_pkg::offset_bits'(cache_pkg::line_words - 1));

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state    <= cache_pkg::idle;
            word_cnt <= '0;
        end else begin
            case (state)
                cache_pkg::idle: begin
                    if (i_req) begin
                        state <= cache_pkg::lookup;
                    end
                end
                cache_pkg::lookup: begin
                    word_cnt <= '0;
                    if (hit) begin
                        state <= cache_pkg::idle;
                    end else if (i_valid && i_dirty) begin
                        state <= cache_pkg::write_back;
                    end else begin
                        state <= cache_pkg::refill;
                    end
                end
                cache_pkg::write_back: begin
                    if (mem.ack) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (last_word) begin
                            state <= cache_pkg::refill;
                        end
                    end
                end
                cache_pkg::refill: begin
                    if (mem.ack) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (last_word) begin
                            state <= cache_pkg::finish;
                        end
                    end
                end
                default: begin
                    state <= cache_pkg::idle;
                end
            endcase
        end
    end

    // request capture
    always_ff @(posedge i_clock) begin
        if (state == cache_pkg::idle && i_req) begin
            req_addr.raw <= i_addr;
            req_wr       <= i_wr;
            req_wdata    <= i_wdata;
        end
    end

    // ####################
    // datapath
    // ####################

    assign serve     = (state == cache_pkg::lookup && hit) || (state == cache_pkg::finish);
    assign line_xfer = (state == cache_pkg::write_back) || (state == cache_pkg::refill);

    assign o_done  = serve;
    assign o_busy  = (state != cache_pkg::idle);
    assign o_rdata = i_ram_rdata;

    assign o_tag_index = req_addr.fields.index;
    assign o_fill      = (state == cache_pkg::refill) && mem.ack && last_word;
    assign o_fill_tag  = req_addr.fields.tag;
    assign o_set_dirty = serve && req_wr;

    // burst walks the line, otherwise the requested word
    assign o_ram_addr  = {req_addr.fields.index, line_xfer ? word_cnt : req_addr.fields.offset};
    assign o_ram_wr    = (serve && req_wr) || ((state == cache_pkg::refill) && mem.ack);
    assign o_ram_wdata = (state == cache_pkg::refill) ? mem.rdata : req_wdata;

    // victim tag is still in the store during write-back
    always_comb begin
        mem_addr.fields.tag    = (state == cache_pkg::write_back) ? i_tag : req_addr.fields.tag;
        mem_addr.fields.index  = req_addr.fields.index;
        mem_addr.fields.offset = word_cnt;
    end

    assign mem.req   = line_xfer;
    assign mem.we    = (state == cache_pkg::write_back);
    assign mem.addr  = mem_addr.raw;
    assign mem.wdata = i_ram_rdata;

    // ####################
    // checks
    // ####################

    a_mem_req_held: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        mem.req && !mem.ack |=> mem.req && $stable(mem.addr) && $stable(mem.we)
    );

    a_no_req_busy: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        i_req |-> !o_busy
    );

endmodule

// File: cache/cache_mem.sv
module cache_mem #(
    parameter int data_width_p = 32,
    parameter int addr_width_p = 8
) (
    input  logic                    i_clock,
    input  logic                    i_wr,
    input  logic [addr_width_p-1:0] i_addr,
    input  logic [data_width_p-1:0] i_data,
    output logic [data_width_p-1:0] o_data
);

    // ####################
    // storage
    // ####################

    logic [data_width_p-1:0] mem_array [2**addr_width_p];

    // single port, write on the edge
    always_ff @(posedge i_clock) begin
        if (i_wr) begin
            mem_array[i_addr] <= i_data;
        end
    end

    // asynchronous read, written word visible next cycle
    assign o_data = mem_array[i_addr];

endmodule

// File: cache/cache_tags.sv
module cache_tags (
    input  logic                             i_clock,
    input  logic                             i_rst_n,
    input  logic [cache_pkg::index_bits-1:0] i_index,
    input  logic                             i_fill,
    input  logic [cache_pkg::tag_bits-1:0]   i_fill_tag,
    input  logic                             i_set_dirty,
    output logic [cache_pkg::tag_bits-1:0]   o_tag,
    output logic                             o_valid,
    output logic                             o_dirty
);

    logic [cache_pkg::tag_bits-1:0]   tag_array [cache_pkg::line_count];
    logic [cache_pkg::line_count-1:0] valid_bits;
    logic [cache_pkg::line_count-1:0] dirty_bits;

    // ####################
    // state bits
    // ####################

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (i_fill) begin
                valid_bits[i_index] <= 1'b1;
                dirty_bits[i_index] <= 1'b0;
            end
            if (i_set_dirty) begin
                dirty_bits[i_index] <= 1'b1;
            end
        end
    end

    // tags only matter once valid
    always_ff @(posedge i_clock) begin
        if (i_fill) begin
            tag_array[i_index] <= i_fill_tag;
        end
    end

    assign o_tag   = tag_array[i_index];
    assign o_valid = valid_bits[i_index];
    assign o_dirty = dirty_bits[i_index];

    // a write only lands on a line that was looked up or refilled
    a_dirty_needs_valid: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        i_set_dirty |-> valid_bits[i_index]
    );

endmodule

// File: common/cache_pkg.sv
package cache_pkg;

    // ####################
    // address geometry
    // ####################

    localparam int addr_width  = 16;
    localparam int data_width  = 32;

    // word within a line
    localparam int offset_bits = 2;
    localparam int line_words  = 2 ** offset_bits;

    // line select
    localparam int index_bits  = 6;
    localparam int line_count  = 2 ** index_bits;

    localparam int tag_bits    = addr_width - index_bits - offset_bits;

    // data ram holds every word of every line
    localparam int mem_addr_width = index_bits + offset_bits;

    // ####################
    // types
    // ####################

    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [index_bits-1:0]  index;
        logic [offset_bits-1:0] offset;
    } addr_fields_t;

    // raw word for the memory port, fields for lookup
    typedef union packed {
        logic [addr_width-1:0] raw;
        addr_fields_t          fields;
    } cache_addr_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        write_back,
        refill,
        finish
    } ctrl_state_t;

endpackage

// File: common/mem_port_if.sv
interface mem_port_if;

    // controller side
    logic                             req;
    logic                             we;
    logic [cache_pkg::addr_width-1:0] addr;
    logic [cache_pkg::data_width-1:0] wdata;

    // memory side
    logic [cache_pkg::data_width-1:0] rdata;
    logic                             ack;

    // one word per ack, request held until then
    modport master (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  ack
    );

    modport slave (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output ack
    );

endinterface

// File: flist.f
common/cache_pkg.sv
common/mem_port_if.sv
cache/cache_mem.sv
cache/cache_tags.sv
cache/cache_ctrl.sv
logic/cache_top.sv
testbench/tb_memory.sv
testbench/tb_cache.sv

// File: logic/cache_top.sv
module cache_top (
    input  logic                             i_clock,
    input  logic                             i_rst_n,

    // processor side
    input  logic                             i_req,
    input  logic                             i_wr,
    input  logic [cache_pkg::addr_width-1:0] i_addr,
    input  logic [cache_pkg::data_width-1:0] i_wdata,
    output logic                             o_done,
    output logic                             o_busy,
    output logic [cache_pkg::data_width-1:0] o_rdata,

    // memory side
    output logic                             o_mem_req,
    output logic                             o_mem_we,
    output logic [cache_pkg::addr_width-1:0] o_mem_addr,
    output logic [cache_pkg::data_width-1:0] o_mem_wdata,
    input  logic [cache_pkg::data_width-1:0] i_mem_rdata,
    input  logic                             i_mem_ack
);

    logic [cache_pkg::index_bits-1:0]     tag_index;
    logic                                 fill;
    logic [cache_pkg::tag_bits-1:0]       fill_tag;
    logic                                 set_dirty;
    logic [cache_pkg::tag_bits-1:0]       tag;
    logic                                 valid;
    logic                                 dirty;
    logic [cache_pkg::mem_addr_width-1:0] ram_addr;
    logic                                 ram_wr;
    logic [cache_pkg::data_width-1:0]     ram_wdata;
    logic [cache_pkg::data_width-1:0]     ram_rdata;

    mem_port_if mem_if ();

    // ####################
    // memory pins
    // ####################

    assign o_mem_req    = mem_if.req;
    assign o_mem_we     = mem_if.we;
    assign o_mem_addr   = mem_if.addr;
    assign o_mem_wdata  = mem_if.wdata;
    assign mem_if.rdata = i_mem_rdata;
    assign mem_if.ack   = i_mem_ack;

    cache_ctrl ctrl0 (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_req       (i_req),
        .i_wr        (i_wr),
        .i_addr      (i_addr),
        .i_wdata     (i_wdata),
        .o_done      (o_done),
        .o_busy      (o_busy),
        .o_rdata     (o_rdata),
        .mem         (mem_if.master),
        .o_tag_index (tag_index),
        .o_fill      (fill),
        .o_fill_tag  (fill_tag),
        .o_set_dirty (set_dirty),
        .i_tag       (tag),
        .i_valid     (valid),
        .i_dirty     (dirty),
        .o_ram_addr  (ram_addr),
        .o_ram_wr    (ram_wr),
        .o_ram_wdata (ram_wdata),
        .i_ram_rdata (ram_rdata)
    );

    cache_tags tags0 (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_index     (tag_index),
        .i_fill      (fill),
        .i_fill_tag  (fill_tag),
        .i_set_dirty (set_dirty),
        .o_tag       (tag),
        .o_valid     (valid),
        .o_dirty     (dirty)
    );

    cache_mem #(
        .data_width_p (cache_pkg::data_width),
        .addr_width_p (cache_pkg::mem_addr_width)
    ) ram0 (
        .i_clock (i_clock),
        .i_wr    (ram_wr),
        .i_addr  (ram_addr),
        .i_data  (ram_wdata),
        .o_data  (ram_rdata)
    );

    // refill must leave the requested line present and tagged
    a_finish_line_present: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        (ctrl0.state == cache_pkg::finish) |-> (valid && tag == fill_tag)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_cache -f flist.f

output="$(./obj_dir/Vtb_cache)"
echo "$output"

if grep -qx "test passed" <<< "$output"; then
    exit 0
else
    exit 1
fi

// File: testbench/tb_cache.sv
module tb_cache;

    localparam int op_count      = 400;
    localparam int reset_cycles  = 16;
    localparam int timeout_limit = op_count * 40 + reset_cycles;

    logic        i_clock;
    logic        i_rst_n;
    logic        i_req;
    logic        i_wr;
    logic [15:0] i_addr;
    logic [31:0] i_wdata;
    logic        o_done;
    logic        o_busy;
    logic [31:0] o_rdata;
    logic        o_mem_req;
    logic        o_mem_we;
    logic [15:0] o_mem_addr;
    logic [31:0] o_mem_wdata;
    logic [31:0] i_mem_rdata;
    logic        i_mem_ack;

    logic [1:0]  mem_delay = 2'd0;
    logic [31:0] expect_word;
    int          mem_errors;
    logic [15:0] stim_lfsr = 16'd83;
    logic [15:0] lat_lfsr  = 16'd83;
    logic [31:0] model_mem [65536];
    logic        shadow_valid [64];
    logic [7:0]  shadow_tag [64];
    logic        shadow_dirty [64];
    logic        xfer_we [$];
    logic [15:0] xfer_addr [$];
    int          checks = 0;
    int          errors = 0;
    int          cycle_count = 0;

    cache_top dut0 (.*);

    tb_memory mem0 (
        .i_clock  (i_clock),
        .i_rst_n  (i_rst_n),
        .i_req    (o_mem_req),
        .i_we     (o_mem_we),
        .i_addr   (o_mem_addr),
        .i_wdata  (o_mem_wdata),
        .i_expect (expect_word),
        .i_delay  (mem_delay),
        .o_rdata  (i_mem_rdata),
        .o_ack    (i_mem_ack),
        .o_errors (mem_errors)
    );

    // a dirty victim must carry what the model holds
    assign expect_word = model_mem[o_mem_addr];

    always #5 i_clock = ~i_clock;

    // ####################
    // random source
    // ####################

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int k = 0; k < count; k++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            value = {value[30:0], stim_lfsr[0]};
        end
    endtask

    // three tags that share the same indices
    function automatic logic [7:0] tag_for(input logic [1:0] sel);
        case (sel)
            2'd1:    return 8'h63;
            2'd2:    return 8'hb5;
            default: return 8'h1c;
        endcase
    endfunction

    always @(posedge i_clock) begin : latency_draw
        logic [15:0] step1;
        logic [15:0] step2;
        step1 = lfsr_next(lat_lfsr);
        step2 = lfsr_next(step1);
        lat_lfsr  <= step2;
        mem_delay <= {step1[0], step2[0]};
    end

    // ####################
    // monitors
    // ####################

    always @(posedge i_clock) begin
        if (o_mem_req && i_mem_ack) begin
            xfer_we.push_back(o_mem_we);
            xfer_addr.push_back(o_mem_addr);
        end
    end

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_limit) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        checks++;
        assert (got === want) else begin
            $display("Mismatch at time %0t: %s, got %08h, expected %08h", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("Error at time %0t: %s", $time, what);
            errors++;
        end
    endtask

    // victim words first when dirty, then the four refill reads
    task automatic check_miss_traffic(input logic [15:0] op_addr, input logic [7:0] old_tag,
                                      input logic write_back);
        int reads_at;
        reads_at = write_back ? 4 : 0;
        check_true(xfer_we.size() == reads_at + 4,
                   $sformatf("miss on %04h moved %0d words", op_addr, xfer_we.size()));
        if (xfer_we.size() == reads_at + 4) begin
            for (int k = 0; k < 4; k++) begin
                if (write_back) begin
                    check_true(xfer_we[k], "write-back word was sent as a read");
                    check_value(32'(xfer_addr[k]), 32'({old_tag, op_addr[7:2], 2'(k)}),
                                "write-back address");
                end
                check_true(!xfer_we[reads_at + k], "refill word was sent as a write");
                check_value(32'(xfer_addr[reads_at + k]), 32'({op_addr[15:2], 2'(k)}),
                            "refill address");
            end
        end
    endtask

    task automatic run_op(input logic op_wr, input logic [15:0] op_addr,
                          input logic [31:0] op_data);
        logic [5:0] idx;
        logic       hit;
        logic       busy_held;
        int         waited;
        idx       = op_addr[7:2];
        hit       = shadow_valid[idx] && shadow_tag[idx] == op_addr[15:8];
        busy_held = 1'b1;
        waited    = 0;
        @(posedge i_clock);
        i_req   <= 1'b1;
        i_wr    <= op_wr;
        i_addr  <= op_addr;
        i_wdata <= op_data;
        @(posedge i_clock);
        i_req <= 1'b0;
        @(negedge i_clock);
        while (!o_done) begin
            busy_held = busy_held && o_busy;
            waited++;
            @(negedge i_clock);
        end
        check_true(busy_held && o_busy, $sformatf("o_busy dropped before o_done on %04h", op_addr));
        if (hit) begin
            check_true(waited == 0 && !o_mem_req && xfer_we.size() == 0,
                       $sformatf("hit on %04h took memory traffic or extra cycles", op_addr));
        end else begin
            check_miss_traffic(op_addr, shadow_tag[idx], shadow_valid[idx] && shadow_dirty[idx]);
        end
        if (op_wr) begin
            model_mem[op_addr] = op_data;
        end else begin
            check_value(o_rdata, model_mem[op_addr], $sformatf("read of %04h", op_addr));
        end
        if (!hit) begin
            shadow_valid[idx] = 1'b1;
            shadow_tag[idx]   = op_addr[15:8];
            shadow_dirty[idx] = 1'b0;
        end
        shadow_dirty[idx] = shadow_dirty[idx] || op_wr;
        xfer_we.delete();
        xfer_addr.delete();
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%s: %0d errors", name, errors + mem_errors - errors_before);
    endtask

    // ####################
    // sequence
    // ####################

    initial begin
        logic [31:0] bits;
        logic        op_wr;
        logic [15:0] op_addr;
        logic [15:0] a;
        int          mark;

        i_clock = 1'b0;
        i_rst_n <= 1'b0;
        i_req   <= 1'b0;
        i_wr    <= 1'b0;
        i_addr  <= '0;
        i_wdata <= '0;
        for (int n = 0; n < 65536; n++) begin
            model_mem[n] = {16'(n), ~16'(n)};
        end
        for (int n = 0; n < 64; n++) begin
            shadow_valid[n] = 1'b0;
            shadow_tag[n]   = '0;
            shadow_dirty[n] = 1'b0;
        end

        mark = errors + mem_errors;
        repeat (reset_cycles - 1) begin
            @(negedge i_clock);
            check_true(!o_done && !o_busy && !o_mem_req, "outputs active during reset");
        end
        @(posedge i_clock);
        i_rst_n <= 1'b1;
        repeat (4) begin
            @(negedge i_clock);
            check_true(!o_done && !o_busy && !o_mem_req, "outputs active before the first request");
        end
        report_test("reset_idle", mark);

        mark = errors + mem_errors;
        for (int n = 0; n < op_count; n++) begin
            draw_bits(1, bits);
            op_wr = bits[0];
            draw_bits(2, bits);
            op_addr[15:8] = tag_for(bits[1:0]);
            draw_bits(3, bits);
            op_addr[7:2] = {bits[2:0], 3'b101};
            draw_bits(2, bits);
            op_addr[1:0] = bits[1:0];
            draw_bits(32, bits);
            run_op(op_wr, op_addr, bits);
        end
        report_test("random_ops", mark);

        // lines still held dirty are the only ones allowed to differ
        mark = errors + mem_errors;
        for (int t = 0; t < 3; t++) begin
            for (int i = 0; i < 8; i++) begin
                for (int off = 0; off < 4; off++) begin
                    a = {tag_for(2'(t)), 3'(i), 3'b101, 2'(off)};
                    if (!(shadow_valid[a[7:2]] && shadow_tag[a[7:2]] == a[15:8]
                          && shadow_dirty[a[7:2]])) begin
                        check_value(mem0.store[a], model_mem[a], $sformatf("backing word %04h", a));
                    end
                end
            end
        end
        report_test("backing_store", mark);

        $display("summary: 3 tests, %0d checks, %0d errors", checks, errors + mem_errors);
        if (errors + mem_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: testbench/tb_memory.sv
module tb_memory (
    input  logic        i_clock,
    input  logic        i_rst_n,
    input  logic        i_req,
    input  logic        i_we,
    input  logic [15:0] i_addr,
    input  logic [31:0] i_wdata,
    input  logic [31:0] i_expect,
    input  logic [1:0]  i_delay,
    output logic [31:0] o_rdata,
    output logic        o_ack,
    output int          o_errors
);

    logic [31:0] store [65536];
    logic        pending;
    logic [1:0]  wait_cnt;

    // every word starts as its own address and its inverse
    initial begin
        for (int a = 0; a < 65536; a++) begin
            store[a] <= {16'(a), ~16'(a)};
        end
        o_ack    <= 1'b0;
        o_rdata  <= '0;
        o_errors <= 0;
        pending  <= 1'b0;
        wait_cnt <= '0;
    end

    // ####################
    // word transfers
    // ####################

    // ack lands i_delay + 1 cycles after a word is first seen
    always @(posedge i_clock) begin
        if (!i_rst_n) begin
            o_ack    <= 1'b0;
            pending  <= 1'b0;
            wait_cnt <= '0;
        end else if (o_ack) begin
            o_ack <= 1'b0;
            if (i_we) begin
                store[i_addr] <= i_wdata;
                assert (i_wdata === i_expect) else begin
                    $display("Mismatch at time %0t: write-back to %04h, got %08h, expected %08h",
                             $time, i_addr, i_wdata, i_expect);
                    o_errors <= o_errors + 1;
                end
            end
        end else if (i_req) begin
            if (pending && wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else if (!pending && i_delay != 2'd0) begin
                pending  <= 1'b1;
                wait_cnt <= i_delay - 2'd1;
            end else begin
                pending <= 1'b0;
                o_ack   <= 1'b1;
                o_rdata <= store[i_addr];
            end
        end
    end

endmodule
